// File: bru_execute_stage.sv
/* ex1 stage, adders and comparators plus per-opcode target, taken and link data
   result goes to the resolve stage as one bundle */
`timescale 1ns/1ns
`include "bru_macros.svh"

module bru_execute_stage
    import bru_pkg::*;
(
    input  logic     CLK,
    input  logic     nRST,

    input  logic     ex_valid,
    input  bru_ex_t  ex,

    // back-pressure
    input  logic     stall_wb,
    output logic     stall_ex1,

    output logic     res_valid,
    output bru_res_t res
);

    logic                 valid_ex1;
    bru_ex_t              ex1;

    logic [`BRU_XLEN-1:0] pc_plus_imm;
    logic [`BRU_XLEN-1:0] a_plus_imm;
    logic [`BRU_XLEN-1:0] seq_step;
    logic [`BRU_XLEN-1:0] pc_plus_seq;
    logic                 a_eq_b;
    logic                 a_eq_zero;
    logic                 a_lts_b;
    logic                 a_ltu_b;
    logic                 br_cond;

    // -------------------------------------------------------------------
    // ex1 register

    assign stall_ex1 = valid_ex1 & stall_wb;

    always_ff @(posedge CLK, negedge nRST) begin
        if (~nRST) begin
            valid_ex1 <= 1'b0;
        end else if (~stall_ex1) begin
            valid_ex1 <= ex_valid;
        end
    end

    always_ff @(posedge CLK) begin
        if (~stall_ex1) begin
            ex1 <= ex;
        end
    end

    // -------------------------------------------------------------------
    // arithmetic

    assign pc_plus_imm = ex1.pc + ex1.imm32;
    assign a_plus_imm  = ex1.a + ex1.imm32;

    // compressed ops with a fall-through or link step by 2
    always_comb begin
        case (ex1.op)
            op_c_jalr, op_c_jal, op_c_beqz, op_c_bnez: seq_step = `BRU_XLEN'(2);
            default:                                   seq_step = `BRU_XLEN'(4);
        endcase
    end
    assign pc_plus_seq = ex1.pc + seq_step;

    assign a_eq_b    = ex1.a == ex1.b;
    assign a_eq_zero = ex1.a == '0;
    assign a_lts_b   = $signed(ex1.a) < $signed(ex1.b);
    assign a_ltu_b   = ex1.a < ex1.b;

    // branch condition by opcode
    always_comb begin
        case (ex1.op)
            op_beq:    br_cond = a_eq_b;
            op_bne:    br_cond = ~a_eq_b;
            op_c_beqz: br_cond = a_eq_zero;
            op_c_bnez: br_cond = ~a_eq_zero;
            op_blt:    br_cond = a_lts_b;
            op_bge:    br_cond = ~a_lts_b;
            op_bltu:   br_cond = a_ltu_b;
            op_bgeu:   br_cond = ~a_ltu_b;
            default:   br_cond = 1'b0;  // not a branch
        endcase
    end

    // -------------------------------------------------------------------
    // per-opcode result

    assign res_valid = valid_ex1;

    always_comb begin
        res.op         = ex1.op;
        res.pc         = ex1.pc;
        res.pred_pc    = ex1.pred_pc;
        res.dest_pr    = ex1.dest_pr;
        res.rob_index  = ex1.rob_index;
        // jump defaults, link is the next sequential pc
        res.target_pc  = pc_plus_imm;
        res.is_taken   = 1'b1;
        res.write_data = pc_plus_seq;

        case (ex1.op)
            op_jalr: res.target_pc = a_plus_imm;
            op_c_jalr, op_c_jr: res.target_pc = ex1.a;
            op_jal, op_c_jal, op_c_j: ;  // defaults hold
            op_lui: begin
                res.is_taken   = 1'b0;
                res.write_data = ex1.imm32;
            end
            op_auipc: begin
                res.is_taken   = 1'b0;
                res.write_data = pc_plus_imm;
            end
            default: begin
                // conditional branches, fall through when not taken
                if (~br_cond) begin
                    res.target_pc = pc_plus_seq;
                    res.is_taken  = 1'b0;
                end
            end
        endcase
    end

endmodule

// File: bru_imm_expand.sv
/* rebuilds the full 32-bit immediate from the compact 20-bit field
   the field layout depends on the opcode class */
`timescale 1ns/1ns
`include "bru_macros.svh"

module bru_imm_expand
    import bru_pkg::*;
(
    input  bru_op_e                     op,
    input  logic [`BRU_IMM20_WIDTH-1:0] imm20,
    output logic [`BRU_XLEN-1:0]        imm32
);

    logic is_u;     // lui, auipc
    logic is_i;     // jalr only

    assign is_u = (op == op_lui) || (op == op_auipc);
    assign is_i = (op == op_jalr);

    always_comb begin
        // sign always sits at imm20[11]
        imm32[31] = imm20[11];

        if (is_u) begin
            imm32[30:20] = imm20[10:0];
        end else begin
            imm32[30:20] = {11{imm20[11]}};
        end

        // i-type and branches sign fill, jumps carry their own bits
        if (is_i || op[3]) begin
            imm32[19:12] = {8{imm20[11]}};
        end else begin
            imm32[19:12] = imm20[19:12];
        end

        if (is_i) begin
            imm32[11] = imm20[11];
        end else if (is_u) begin
            imm32[11] = 1'b0;
        end else begin
            imm32[11] = imm20[0];   // j/b offset bit 11 parked in bit 0
        end

        if (is_u) begin
            imm32[10:1] = '0;
        end else begin
            imm32[10:1] = imm20[10:1];
        end

        // halfword aligned except for jalr
        imm32[0] = is_i ? imm20[0] : 1'b0;
    end

endmodule

// File: bru_macros.svh
/* widths and constants for the branch resolution pipeline
   included by the package and by every stage that sizes a signal */
`ifndef BRU_MACROS_SVH
`define BRU_MACROS_SVH

// data and pc width
`define BRU_XLEN 32

// compact immediate as carried by the issue queue
`define BRU_IMM20_WIDTH 20

// physical register tag and rob index
`define BRU_LOG_PR_COUNT 7
`define BRU_LOG_ROB_ENTRIES 7

// high pc bits that must agree for an in-range target
`define BRU_UPPER_PC_WIDTH 19

`endif

// File: bru_operand_stage.sv
/* operand capture stage, takes one issued op per cycle and expands its immediate
   holds while the execute stage pushes back */
`timescale 1ns/1ns
`include "bru_macros.svh"

module bru_operand_stage
    import bru_pkg::*;
(
    input  logic       CLK,
    input  logic       nRST,

    // issue side
    input  logic       issue_valid,
    input  bru_issue_t issue,
    output logic       issue_ready,

    // towards ex1
    input  logic       stall_ex1,
    output logic       ex_valid,
    output bru_ex_t    ex
);

    logic                 valid_oc;
    bru_issue_t           oc;
    logic                 stall_oc;
    logic [`BRU_XLEN-1:0] imm32;

    // -------------------------------------------------------------------
    // control

    assign stall_oc    = valid_oc & stall_ex1;   // only a real op blocks
    assign issue_ready = ~valid_oc | ~stall_oc;
    assign ex_valid    = valid_oc & ~stall_oc;

    always_ff @(posedge CLK, negedge nRST) begin
        if (~nRST) begin
            valid_oc <= 1'b0;
        end else if (~stall_oc) begin
            valid_oc <= issue_valid;
        end
    end

    // payload, held in place on a stall
    always_ff @(posedge CLK) begin
        if (~stall_oc) begin
            oc <= issue;
        end
    end

    // -------------------------------------------------------------------
    // immediate and ex1 bundle

    bru_imm_expand i_imm_expand (
        .op    (oc.op),
        .imm20 (oc.imm20),
        .imm32 (imm32)
    );

    always_comb begin
        ex.op        = oc.op;
        ex.pc        = oc.pc;
        ex.pred_pc   = oc.pred_pc;
        ex.imm32     = imm32;
        ex.a         = oc.a;
        ex.b         = oc.b;
        ex.dest_pr   = oc.dest_pr;
        ex.rob_index = oc.rob_index;
    end

endmodule

// File: bru_pipeline.sv
/* branch resolution pipeline top, operand capture then ex1, ex2 and writeback
   back-pressure from either output sink stalls the pipeline from the back */
`timescale 1ns/1ns

module bru_pipeline
    import bru_pkg::*;
(
    input  logic       CLK,
    input  logic       nRST,

    // issue
    input  logic       issue_valid,
    input  bru_issue_t issue,
    output logic       issue_ready,

    // register writeback
    output logic       wb_valid,
    output bru_wb_t    wb,
    input  logic       wb_ready,

    // branch notification to rob
    output logic       notif_valid,
    output bru_notif_t notif,
    input  logic       notif_ready
);

    logic     ex_valid;
    bru_ex_t  ex;
    logic     res_valid;
    bru_res_t res;
    logic     stall_ex1;
    logic     stall_wb;

    // -------------------------------------------------------------------
    // stages

    bru_operand_stage i_operand_stage (
        .CLK         (CLK),
        .nRST        (nRST),
        .issue_valid (issue_valid),
        .issue       (issue),
        .issue_ready (issue_ready),
        .stall_ex1   (stall_ex1),
        .ex_valid    (ex_valid),
        .ex          (ex)
    );

    bru_execute_stage i_execute_stage (
        .CLK       (CLK),
        .nRST      (nRST),
        .ex_valid  (ex_valid),
        .ex        (ex),
        .stall_wb  (stall_wb),
        .stall_ex1 (stall_ex1),
        .res_valid (res_valid),
        .res       (res)
    );

    bru_resolve_stage i_resolve_stage (
        .CLK         (CLK),
        .nRST        (nRST),
        .res_valid   (res_valid),
        .res         (res),
        .stall_wb    (stall_wb),
        .wb_ready    (wb_ready),
        .wb_valid    (wb_valid),
        .wb          (wb),
        .notif_ready (notif_ready),
        .notif_valid (notif_valid),
        .notif       (notif)
    );

endmodule

// File: bru_pkg.sv
/* opcode encoding and stage bundles of the branch resolution pipeline
   imported by every stage and by the testbench */
`include "bru_macros.svh"

package bru_pkg;

    // bit 3 set marks a conditional branch
    typedef enum logic [3:0] {
        op_jalr   = 4'h0,
        op_c_jalr = 4'h1,
        op_jal    = 4'h2,
        op_c_jal  = 4'h3,
        op_c_j    = 4'h4,
        op_c_jr   = 4'h5,
        op_lui    = 4'h6,
        op_auipc  = 4'h7,
        op_beq    = 4'h8,
        op_bne    = 4'h9,
        op_c_beqz = 4'ha,
        op_c_bnez = 4'hb,
        op_blt    = 4'hc,
        op_bge    = 4'hd,
        op_bltu   = 4'he,
        op_bgeu   = 4'hf
    } bru_op_e;

    // -------------------------------------------------------------------
    // stage bundles

    typedef struct packed {
        bru_op_e                         op;
        logic [`BRU_XLEN-1:0]            pc;
        logic [`BRU_XLEN-1:0]            pred_pc;
        logic [`BRU_IMM20_WIDTH-1:0]     imm20;
        logic [`BRU_XLEN-1:0]            a;
        logic [`BRU_XLEN-1:0]            b;
        logic [`BRU_LOG_PR_COUNT-1:0]    dest_pr;
        logic [`BRU_LOG_ROB_ENTRIES-1:0] rob_index;
    } bru_issue_t;

    typedef struct packed {
        bru_op_e                         op;
        logic [`BRU_XLEN-1:0]            pc;
        logic [`BRU_XLEN-1:0]            pred_pc;
        logic [`BRU_XLEN-1:0]            imm32;     // already expanded
        logic [`BRU_XLEN-1:0]            a;
        logic [`BRU_XLEN-1:0]            b;
        logic [`BRU_LOG_PR_COUNT-1:0]    dest_pr;
        logic [`BRU_LOG_ROB_ENTRIES-1:0] rob_index;
    } bru_ex_t;

    typedef struct packed {
        bru_op_e                         op;
        logic [`BRU_XLEN-1:0]            pc;
        logic [`BRU_XLEN-1:0]            pred_pc;
        logic [`BRU_XLEN-1:0]            target_pc;
        logic                            is_taken;
        logic [`BRU_XLEN-1:0]            write_data;
        logic [`BRU_LOG_PR_COUNT-1:0]    dest_pr;
        logic [`BRU_LOG_ROB_ENTRIES-1:0] rob_index;
    } bru_res_t;

    typedef struct packed {
        logic [`BRU_XLEN-1:0]            data;
        logic [`BRU_LOG_PR_COUNT-1:0]    pr;
        logic [`BRU_LOG_ROB_ENTRIES-1:0] rob_index;
    } bru_wb_t;

    typedef struct packed {
        logic [`BRU_LOG_ROB_ENTRIES-1:0] rob_index;
        logic                            is_mispredict;
        logic                            is_taken;
        logic                            is_out_of_range;
        logic [`BRU_XLEN-1:0]            start_pc;
        logic [`BRU_XLEN-1:0]            target_pc;
    } bru_notif_t;

endpackage

// File: bru_resolve_stage.sv
/* ex2 and output stages, mispredict and range checks and the two output ports
   writeback and branch notification each wait for their own ready */
`timescale 1ns/1ns
`include "bru_macros.svh"

module bru_resolve_stage
    import bru_pkg::*;
(
    input  logic       CLK,
    input  logic       nRST,

    input  logic       res_valid,
    input  bru_res_t   res,
    output logic       stall_wb,    // back-pressure to ex1

    // writeback port
    input  logic       wb_ready,
    output logic       wb_valid,
    output bru_wb_t    wb,

    // branch notification port
    input  logic       notif_ready,
    output logic       notif_valid,
    output bru_notif_t notif
);

    logic       valid_ex2;
    bru_res_t   ex2;
    logic       out_blocked;
    logic       next_wb_valid;
    logic       next_notif_valid;
    bru_wb_t    next_wb;
    bru_notif_t next_notif;

    // -------------------------------------------------------------------
    // stall

    // either output still waiting on its sink
    assign out_blocked = (wb_valid & ~wb_ready) | (notif_valid & ~notif_ready);

    // ex2 only holds when it has something to hold
    assign stall_wb = valid_ex2 & out_blocked;

    // -------------------------------------------------------------------
    // ex2 register

    always_ff @(posedge CLK, negedge nRST) begin
        if (~nRST) begin
            valid_ex2 <= 1'b0;
        end else if (~stall_wb) begin
            valid_ex2 <= res_valid;
        end
    end

    always_ff @(posedge CLK) begin
        if (~stall_wb) begin
            ex2 <= res;
        end
    end

    // -------------------------------------------------------------------
    // next outputs

    always_comb begin
        next_wb.data      = ex2.write_data;
        next_wb.pr        = ex2.dest_pr;
        next_wb.rob_index = ex2.rob_index;

        next_notif.rob_index       = ex2.rob_index;
        next_notif.is_mispredict   = ex2.target_pc != ex2.pred_pc;
        next_notif.is_taken        = ex2.is_taken;
        next_notif.is_out_of_range =
            ex2.target_pc[`BRU_XLEN-1 -: `BRU_UPPER_PC_WIDTH] !=
            ex2.pc[`BRU_XLEN-1 -: `BRU_UPPER_PC_WIDTH];
        next_notif.start_pc        = ex2.pc;
        next_notif.target_pc       = ex2.target_pc;
    end

    // which port each opcode uses
    always_comb begin
        next_wb_valid    = 1'b0;
        next_notif_valid = 1'b0;
        if (ex2.op[3]) begin
            next_notif_valid = valid_ex2;   // conditional branches
        end else begin
            case (ex2.op)
                op_jalr, op_c_jalr, op_jal, op_c_jal: begin
                    next_wb_valid    = valid_ex2;
                    next_notif_valid = valid_ex2;
                end
                op_c_j, op_c_jr: next_notif_valid = valid_ex2;
                op_lui, op_auipc: next_wb_valid = valid_ex2;
                default: ;
            endcase
        end
    end

    // -------------------------------------------------------------------
    // output registers

    always_ff @(posedge CLK, negedge nRST) begin
        if (~nRST) begin
            wb_valid    <= 1'b0;
            notif_valid <= 1'b0;
        end else if (out_blocked) begin
            // an accepted side drops, the other keeps waiting
            wb_valid    <= wb_valid & ~wb_ready;
            notif_valid <= notif_valid & ~notif_ready;
        end else begin
            wb_valid    <= next_wb_valid;
            notif_valid <= next_notif_valid;
        end
    end

    always_ff @(posedge CLK) begin
        if (~out_blocked) begin
            wb    <= next_wb;
            notif <= next_notif;
        end
    end

endmodule

// File: bru_stimulus.txt
# op pc pred_pc imm20 a b dest_pr rob_index, all hex
# expected: wb notif write_data target taken mispredict out_of_range
0 00004100 00004810 00010 00004800 00000000 05 01 1 1 00004104 00004810 1 0 0
0 00004200 00004204 12ff8 00010000 00000000 06 02 1 1 00004204 0000fff8 1 1 1
1 00004300 00004a02 00000 00004a02 00000000 07 03 1 1 00004302 00004a02 1 0 0
2 00004400 00004404 01234 00000000 00000000 08 04 1 1 00004404 00005634 1 1 0
2 00004500 00003d00 ff801 00000000 00000000 09 05 1 1 00004504 00003d00 1 0 1
3 00004600 00004610 00010 00000000 00000000 0a 06 1 1 00004602 00004610 1 0 0
4 00004700 00004702 fffee 00000000 00000000 0b 07 0 1 00000000 00003eee 1 1 1
5 00004780 00004800 00000 00004800 00000000 0c 08 0 1 00000000 00004800 1 0 0
6 00004900 00000000 45123 00000000 00000000 0d 09 1 0 12345000 00000000 0 0 0
6 00004a00 00000000 dbdea 00000000 00000000 0e 0a 1 0 deadb000 00000000 0 0 0
7 00004b00 00000000 00001 00000000 00000000 0f 0b 1 0 00104b00 00000000 0 0 0
7 00004c04 00000000 00fff 00000000 00000000 10 0c 1 0 fff04c04 00000000 0 0 0
8 00004d00 00004d40 00040 00000005 00000005 11 0d 0 1 00000000 00004d40 1 0 0
8 00004d10 00004d50 00040 00000005 00000006 12 0e 0 1 00000000 00004d14 0 1 0
9 00004e00 00004e04 00f80 00000001 00000002 13 0f 0 1 00000000 00004580 1 1 0
9 00004e10 00004e14 00040 80000000 80000000 14 10 0 1 00000000 00004e14 0 0 0
a 00004f00 00004f02 00040 00000000 00000012 15 11 0 1 00000000 00004f40 1 1 0
a 00004f10 00004f12 00040 00000001 00000000 16 12 0 1 00000000 00004f12 0 0 0
b 00005000 00005040 00040 ffffffff 00000000 17 13 0 1 00000000 00005040 1 0 0
b 00005010 00005050 00040 00000000 00000000 18 14 0 1 00000000 00005012 0 1 0
c 00005100 00005104 00040 80000000 00000001 19 15 0 1 00000000 00005140 1 1 0
c 00005110 00005114 00040 00000001 ffffffff 1a 16 0 1 00000000 00005114 0 0 0
d 00005200 00005240 00040 00000001 ffffffff 1b 17 0 1 00000000 00005240 1 0 0
d 00005210 00005250 00040 80000000 00000001 1c 18 0 1 00000000 00005214 0 1 0
e 00005300 00005340 00040 00000001 ffffffff 1d 19 0 1 00000000 00005340 1 0 0
e 00005310 00005314 00040 80000000 00000001 1e 1a 0 1 00000000 00005314 0 0 0
f 00005ff0 00005ff4 00040 80000000 00000001 1f 1b 0 1 00000000 00006030 1 1 1
f 00005400 00005404 00040 00000001 ffffffff 20 1c 0 1 00000000 00005404 0 0 0
0 00005500 00010000 00000 00010000 00000000 21 1d 1 1 00005504 00010000 1 0 1
2 00005ff0 00005ff8 00008 00000000 00000000 22 1e 1 1 00005ff4 00005ff8 1 0 0
3 00004000 00004000 00001 00000000 00000000 23 1f 1 1 00004002 00004800 1 1 0

// File: sources.f
+incdir+.
bru_pkg.sv
bru_imm_expand.sv
bru_operand_stage.sv
bru_execute_stage.sv
bru_resolve_stage.sv
bru_pipeline.sv
tb_bru_pipeline.sv

// File: tb_bru_pipeline.sv
/* self-checking testbench for the branch resolution pipeline
   replays bru_stimulus.txt under random back-pressure and checks both output ports */
`timescale 1ns/1ns
`include "bru_macros.svh"

module tb_bru_pipeline
    import bru_pkg::*;
();

    logic       CLK;
    logic       nRST;
    logic       issue_valid;
    bru_issue_t issue;
    logic       issue_ready;
    logic       wb_valid;
    bru_wb_t    wb;
    logic       wb_ready;
    logic       notif_valid;
    bru_notif_t notif;
    logic       notif_ready;

    // one entry per stimulus line
    bru_issue_t issue_tab[$];
    bru_wb_t    wb_tab[$];
    bru_notif_t notif_tab[$];
    bit         wb_use[$];
    bit         notif_use[$];

    // results still owed by the dut, oldest first
    bru_wb_t    wb_expect_q[$];
    bru_notif_t notif_expect_q[$];

    integer seed;
    int     next_op       = 0;
    bit     issue_hold    = 1'b0;   // op presented but not yet taken
    int     cycle_count   = 0;
    int     timeout_limit = 0;
    int     both_accepts  = 0;
    int     wb_errors     = 0;
    int     notif_errors  = 0;
    int     other_errors  = 0;

    bru_pipeline i_dut (
        .CLK         (CLK),
        .nRST        (nRST),
        .issue_valid (issue_valid),
        .issue       (issue),
        .issue_ready (issue_ready),
        .wb_valid    (wb_valid),
        .wb          (wb),
        .wb_ready    (wb_ready),
        .notif_valid (notif_valid),
        .notif       (notif),
        .notif_ready (notif_ready)
    );

    initial begin
        CLK = 1'b0;
        forever #50 CLK = ~CLK;
    end

    // ----------------------------------------------------------------------
    // compare helpers

    function automatic int field_mismatch(string name, logic [31:0] got, logic [31:0] exp);
        if (got !== exp) begin
            $display("[ERROR] %0t %s got %h expected %h", $time, name, got, exp);
            return 1;
        end
        return 0;
    endfunction

    task automatic check_wb(input bru_wb_t got, input bru_wb_t exp);
        wb_errors += field_mismatch("wb.data", got.data, exp.data);
        wb_errors += field_mismatch("wb.pr", got.pr, exp.pr);
        wb_errors += field_mismatch("wb.rob_index", got.rob_index, exp.rob_index);
    endtask

    task automatic check_notif(input bru_notif_t got, input bru_notif_t exp);
        notif_errors += field_mismatch("notif.rob_index", got.rob_index, exp.rob_index);
        notif_errors += field_mismatch("notif.is_mispredict", got.is_mispredict,
                                       exp.is_mispredict);
        notif_errors += field_mismatch("notif.is_taken", got.is_taken, exp.is_taken);
        notif_errors += field_mismatch("notif.is_out_of_range", got.is_out_of_range,
                                       exp.is_out_of_range);
        notif_errors += field_mismatch("notif.start_pc", got.start_pc, exp.start_pc);
        notif_errors += field_mismatch("notif.target_pc", got.target_pc, exp.target_pc);
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        other_errors += field_mismatch(name, got, exp);
    endtask

    task automatic finish_run();
        $display("errors: writeback %0d, notification %0d, other %0d",
                 wb_errors, notif_errors, other_errors);
        if (wb_errors + notif_errors + other_errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    endtask

    // ----------------------------------------------------------------------
    // stimulus file

    task automatic load_stimulus();
        int                              fd;
        int                              n;
        string                           line;
        logic [3:0]                      op_v;
        logic [`BRU_XLEN-1:0]            pc_v;
        logic [`BRU_XLEN-1:0]            pred_v;
        logic [`BRU_IMM20_WIDTH-1:0]     imm_v;
        logic [`BRU_XLEN-1:0]            a_v;
        logic [`BRU_XLEN-1:0]            b_v;
        logic [`BRU_LOG_PR_COUNT-1:0]    pr_v;
        logic [`BRU_LOG_ROB_ENTRIES-1:0] rob_v;
        logic                            wb_v;
        logic                            notif_v;
        logic [`BRU_XLEN-1:0]            data_v;
        logic [`BRU_XLEN-1:0]            target_v;
        logic                            taken_v;
        logic                            misp_v;
        logic                            oor_v;
        bru_issue_t                      op_rec;
        bru_wb_t                         wb_rec;
        bru_notif_t                      notif_rec;

        fd = $fopen("bru_stimulus.txt", "r");
        if (fd == 0) begin
            $display("could not open bru_stimulus.txt");
            other_errors++;
            return;
        end
        while ($fgets(line, fd) != 0) begin
            if (line.len() == 0 || line[0] == "#") begin
                continue;   // header
            end
            n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                        op_v, pc_v, pred_v, imm_v, a_v, b_v, pr_v, rob_v,
                        wb_v, notif_v, data_v, target_v, taken_v, misp_v, oor_v);
            if (n <= 0) begin
                continue;
            end
            if (n != 15) begin
                $display("malformed stimulus line: %s", line);
                other_errors++;
                continue;
            end
            op_rec.op        = bru_op_e'(op_v);
            op_rec.pc        = pc_v;
            op_rec.pred_pc   = pred_v;
            op_rec.imm20     = imm_v;
            op_rec.a         = a_v;
            op_rec.b         = b_v;
            op_rec.dest_pr   = pr_v;
            op_rec.rob_index = rob_v;

            wb_rec.data      = data_v;
            wb_rec.pr        = pr_v;
            wb_rec.rob_index = rob_v;

            notif_rec.rob_index       = rob_v;
            notif_rec.is_mispredict   = misp_v;
            notif_rec.is_taken        = taken_v;
            notif_rec.is_out_of_range = oor_v;
            notif_rec.start_pc        = pc_v;
            notif_rec.target_pc       = target_v;

            issue_tab.push_back(op_rec);
            wb_tab.push_back(wb_rec);
            notif_tab.push_back(notif_rec);
            wb_use.push_back(wb_v);
            notif_use.push_back(notif_v);
        end
        $fclose(fd);
    endtask

    // ----------------------------------------------------------------------
    // one clock cycle, inputs on the falling edge

    task automatic step_cycle(input bit random_ready);
        logic [31:0] rnd;

        rnd = $random(seed);
        @(negedge CLK);
        if (random_ready) begin
            wb_ready    = rnd[0];
            notif_ready = rnd[4];
        end else begin
            wb_ready    = 1'b1;
            notif_ready = 1'b1;
        end
        if (!issue_hold) begin
            // roughly one idle slot in four
            if (next_op < issue_tab.size() && rnd[9:8] != 2'b00) begin
                issue_valid = 1'b1;
                issue       = issue_tab[next_op];
            end else begin
                issue_valid = 1'b0;
            end
        end
        #1;
        // levels now hold until the next rising edge
        if (issue_valid && issue_ready) begin
            if (wb_use[next_op]) begin
                wb_expect_q.push_back(wb_tab[next_op]);
            end
            if (notif_use[next_op]) begin
                notif_expect_q.push_back(notif_tab[next_op]);
            end
            next_op++;
            issue_hold = 1'b0;
        end else begin
            issue_hold = issue_valid;
        end
        if (wb_valid && wb_ready && notif_valid && notif_ready) begin
            both_accepts++;
        end
        if (wb_valid && wb_ready) begin
            if (wb_expect_q.size() == 0) begin
                $display("%0t writeback seen with nothing expected", $time);
                other_errors++;
            end else begin
                check_wb(wb, wb_expect_q.pop_front());
            end
        end
        if (notif_valid && notif_ready) begin
            if (notif_expect_q.size() == 0) begin
                $display("%0t notification seen with nothing expected", $time);
                other_errors++;
            end else begin
                check_notif(notif, notif_expect_q.pop_front());
            end
        end
    endtask

    task automatic run_tests();
        repeat (16) @(posedge CLK);
        @(negedge CLK);
        nRST = 1'b1;
        #1;
        check_flag("wb_valid", wb_valid, 1'b0);
        check_flag("notif_valid", notif_valid, 1'b0);
        check_flag("issue_ready", issue_ready, 1'b1);

        while (next_op < issue_tab.size() || wb_expect_q.size() != 0 ||
               notif_expect_q.size() != 0) begin
            step_cycle(1'b1);
        end
        // drain window, sinks always ready, nothing should show up
        repeat (8) begin
            step_cycle(1'b0);
        end
        $display("%0d ops issued, %0d cycles with both outputs taken together",
                 next_op, both_accepts);
    endtask

    // ----------------------------------------------------------------------
    // main sequence and watchdog

    initial begin : main
        nRST        = 1'b0;
        issue_valid = 1'b0;
        issue       = '0;
        wb_ready    = 1'b0;
        notif_ready = 1'b0;
        seed        = 32'h7c4cba4f;
        load_stimulus();
        if (issue_tab.size() == 0) begin
            $display("no operations found in bru_stimulus.txt");
            other_errors++;
        end else begin
            timeout_limit = 16 + issue_tab.size() * 12;
            run_tests();
        end
        finish_run();
    end

    initial begin : watchdog
        wait (timeout_limit > 0);
        while (cycle_count < timeout_limit) begin
            @(posedge CLK);
            cycle_count++;
        end
        $display("timeout after %0d cycles, results missing: %0d writeback, %0d notification",
                 cycle_count, wb_expect_q.size(), notif_expect_q.size());
        $display("%0d of %0d ops were never issued", issue_tab.size() - next_op,
                 issue_tab.size());
        other_errors++;
        finish_run();
    end

endmodule
